// File: common/rhDmaPkg.sv
// Sequencer state and function code types of the RH11 DMA engine
// Only the codes listed below start any action

package rhDmaPkg;

   // CS1 function codes, bits 5:1 of CS1
   typedef enum logic [4:0]
   {
      // No operation
      fnNop       = 5'd0,
      // Drive clear, CS1 code 04 octal
      fnDriveClr  = 5'd2,
      // Memory to drive, CS1 code 061 octal
      fnWriteData = 5'd24,
      // Drive to memory, CS1 code 071 octal
      fnReadData  = 5'd28
   } func_t;

   // DMA sequencer states
   typedef enum logic [2:0]
   {
      sIdle,
      sDrive,
      sMemReq,
      sMemRel,
      sDone
   } dmaState_t;

endpackage

// File: common/rhRegPkg.sv
// Register select and device write word types of the RH11 model
// The CS1 view follows the bit positions in the constants header

`include "rh_consts.svh"

package rhRegPkg;

   // Which register a device cycle addresses
   typedef enum logic [1:0]
   {
      selNone,
      selCs1,
      selWc,
      selBa
   } regSel_t;

   // CS1 fields as written by the host
   typedef struct packed
   {
      // Bits 15:10 not modeled
      logic [5:0] unused;
      // Address extension, memory address bits 17:16
      logic [1:0] ae;
      logic       rdy;
      logic       ie;
      // Function code, rhDmaPkg::func_t values
      logic [4:0] func;
      logic       go;
   } cs1Fields_t;

   // One written word, seen either way
   // Raw for WC and BA, fields for CS1
   typedef union packed
   {
      logic [`RH_WORD_WIDTH-1:0] raw;
      cs1Fields_t                cs1;
   } devWord_u;

endpackage

// File: common/rh_consts.svh
// Widths, register offsets and CS1 bit positions of the RH11 data channel model
// Device data word is numbered big-endian [0:35], registers are 16 bits little-endian
// Only the low 16 bits of the device word carry register data
`ifndef RH_CONSTS_SVH
`define RH_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// Bus widths
//////////////////////////////////////////////////////////////////////

// KS-10 device data bus
`define RH_DEV_WIDTH 36
// Register and memory word
`define RH_WORD_WIDTH 16
// Memory byte address, two extension bits plus BA
`define RH_ADDR_WIDTH 18

//////////////////////////////////////////////////////////////////////
// Register offsets on devAddr
//////////////////////////////////////////////////////////////////////

`define RH_OFF_CS1 3'd0
`define RH_OFF_WC 3'd2
`define RH_OFF_BA 3'd4

//////////////////////////////////////////////////////////////////////
// CS1 bit positions
//////////////////////////////////////////////////////////////////////

`define RH_CS1_GO 0
`define RH_CS1_FUNC 5:1
`define RH_CS1_IE 6
`define RH_CS1_RDY 7
`define RH_CS1_AE 9:8

// Byte lanes of a little-endian device word
`define RH_HI(d) d[15:8]
`define RH_LO(d) d[7:0]

`endif

// File: design/rhDmaCtrl.sv
// CS1 register and DMA sequencer of the RH11 data channel
// One word per step, memory and drive handshakes have no timeout
// While busy only IE can be written, GO and drive clear are ignored
`timescale 1ns/1ns

`include "rh_consts.svh"

module rhDmaCtrl
(
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      devReset,
   input  logic                      cs1Write,
   input  rhRegPkg::devWord_u        writeWord,
   input  logic                      wcLast,
   input  logic [`RH_WORD_WIDTH-1:0] ba,
   output logic [`RH_WORD_WIDTH-1:0] cs1Value,
   output logic                      clrPulse,
   output logic                      dmaStep,
   output logic                      irq,
   output logic                      memReq,
   output logic                      memWrite,
   output logic [`RH_ADDR_WIDTH-1:0] memAddr,
   output logic [`RH_WORD_WIDTH-1:0] memDataO,
   input  logic                      memAck,
   input  logic [`RH_WORD_WIDTH-1:0] memDataI,
   input  logic [`RH_WORD_WIDTH-1:0] driveInData,
   input  logic                      driveInValid,
   output logic                      driveInReady,
   output logic [`RH_WORD_WIDTH-1:0] driveOutData,
   output logic                      driveOutValid,
   input  logic                      driveOutReady
);

   rhDmaPkg::dmaState_t       state;
   rhDmaPkg::func_t           func;
   logic                      ie;
   logic                      rdy;
   logic [1:0]                ae;
   // Direction of the running transfer, drive to memory when set
   logic                      dirRead;
   // Word in flight between memory and drive
   logic [`RH_WORD_WIDTH-1:0] dataReg;
   logic                      readFn;
   logic                      startXfer;

   assign readFn    = writeWord.cs1.func == rhDmaPkg::fnReadData;
   assign startXfer = cs1Write & writeWord.cs1.go & rdy &
                      (readFn | (writeWord.cs1.func == rhDmaPkg::fnWriteData));

   // CS1 read view, GO shows as busy
   always_comb
   begin
      cs1Value              = '0;
      cs1Value[`RH_CS1_GO]   = ~rdy;
      cs1Value[`RH_CS1_FUNC] = func;
      cs1Value[`RH_CS1_IE]   = ie;
      cs1Value[`RH_CS1_RDY]  = rdy;
      cs1Value[`RH_CS1_AE]   = ae;
   end

   //////////////////////////////////////////////////////////////////////
   // Bus outputs
   //////////////////////////////////////////////////////////////////////

   assign memReq        = state == rhDmaPkg::sMemReq;
   // Read data function writes memory
   assign memWrite      = dirRead;
   assign memAddr       = {ae, ba};
   assign memDataO      = dataReg;
   assign driveOutData  = dataReg;
   assign driveInReady  = (state == rhDmaPkg::sDrive) & dirRead & ~devReset;
   assign driveOutValid = (state == rhDmaPkg::sDrive) & ~dirRead;

   // Step after the memory release on reads, after the drive takes the word on writes
   assign dmaStep = ((state == rhDmaPkg::sMemRel) & dirRead & ~memAck) |
                    ((state == rhDmaPkg::sDrive) & ~dirRead & driveOutReady & ~devReset);

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state    <= rhDmaPkg::sIdle;
         func     <= rhDmaPkg::fnNop;
         ie       <= 1'b0;
         rdy      <= 1'b1;
         ae       <= '0;
         dirRead  <= 1'b0;
         irq      <= 1'b0;
         clrPulse <= 1'b0;
      end
      else
      begin
         clrPulse <= cs1Write & rdy & (writeWord.cs1.func == rhDmaPkg::fnDriveClr);
         // Any CS1 write drops a pending interrupt
         if (cs1Write)
         begin
            irq <= 1'b0;
            ie  <= writeWord.cs1.ie;
         end
         if (cs1Write && rdy)
         begin
            func <= rhDmaPkg::func_t'(writeWord.cs1.func);
            ae   <= writeWord.cs1.ae;
         end
         case (state)
            rhDmaPkg::sIdle:
               if (startXfer)
               begin
                  rdy     <= 1'b0;
                  dirRead <= readFn;
                  // Writes fetch from memory first
                  state   <= readFn ? rhDmaPkg::sDrive : rhDmaPkg::sMemReq;
               end
            rhDmaPkg::sDrive:
               // Device reset aborts between memory cycles
               if (devReset)
                  state <= rhDmaPkg::sDone;
               else if (dirRead && driveInValid)
                  state <= rhDmaPkg::sMemReq;
               else if (!dirRead && driveOutReady)
                  state <= wcLast ? rhDmaPkg::sDone : rhDmaPkg::sMemReq;
            rhDmaPkg::sMemReq:
               if (memAck)
                  state <= rhDmaPkg::sMemRel;
            rhDmaPkg::sMemRel:
               // Wait for memAck to fall before anything new
               if (!memAck)
               begin
                  if (dirRead && wcLast)
                     state <= rhDmaPkg::sDone;
                  else
                     state <= rhDmaPkg::sDrive;
               end
            rhDmaPkg::sDone:
            begin
               rdy   <= 1'b1;
               state <= rhDmaPkg::sIdle;
               if (ie && !cs1Write)
                  irq <= 1'b1;
            end
            default:
               state <= rhDmaPkg::sIdle;
         endcase
      end
   end

   // Data path, drive word or memory read data
   always_ff @(posedge clk)
   begin
      if (state == rhDmaPkg::sDrive && dirRead && driveInValid)
         dataReg <= driveInData;
      else if (state == rhDmaPkg::sMemReq && !dirRead && memAck)
         dataReg <= memDataI;
   end

   // Four-phase memory rule, no new request over an old acknowledge
   assert property (@(posedge clk) disable iff (rst)
      $rose(memReq) |-> !memAck);

endmodule

// File: design/rhTop.sv
// RH11 data channel top, register decode, WC, BA and DMA sequencer
// Single channel and single drive, no interrupt vector
`timescale 1ns/1ns

`include "rh_consts.svh"

module rhTop
(
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      devReset,
   // Device bus
   input  logic                      devReq,
   input  logic                      devWrite,
   input  logic [2:0]                devAddr,
   input  logic                      devLoByte,
   input  logic                      devHiByte,
   input  logic [0:`RH_DEV_WIDTH-1]  devDataI,
   output logic                      devAck,
   output logic [0:`RH_DEV_WIDTH-1]  devDataO,
   // Memory
   output logic                      memReq,
   output logic                      memWrite,
   output logic [`RH_ADDR_WIDTH-1:0] memAddr,
   output logic [`RH_WORD_WIDTH-1:0] memDataO,
   input  logic                      memAck,
   input  logic [`RH_WORD_WIDTH-1:0] memDataI,
   // Drive data ports
   input  logic [`RH_WORD_WIDTH-1:0] driveInData,
   input  logic                      driveInValid,
   output logic                      driveInReady,
   output logic [`RH_WORD_WIDTH-1:0] driveOutData,
   output logic                      driveOutValid,
   input  logic                      driveOutReady,
   output logic                      irq
);

   logic [`RH_WORD_WIDTH-1:0] wc;
   logic [`RH_WORD_WIDTH-1:0] ba;
   logic [`RH_WORD_WIDTH-1:0] cs1Value;
   logic                      wcWrite;
   logic                      baWrite;
   logic                      cs1Write;
   rhRegPkg::devWord_u        writeWord;
   logic                      loByte;
   logic                      hiByte;
   logic                      wcLast;
   logic                      dmaStep;
   logic                      clrPulse;

   rhRegDecode uDecode
   (
      .clk(clk), .rst(rst),
      .devReq(devReq), .devWrite(devWrite), .devAddr(devAddr),
      .devLoByte(devLoByte), .devHiByte(devHiByte), .devDataI(devDataI),
      .wcValue(wc), .baValue(ba), .cs1Value(cs1Value),
      .devAck(devAck), .devDataO(devDataO),
      .wcWrite(wcWrite), .baWrite(baWrite), .cs1Write(cs1Write),
      .writeWord(writeWord), .loByte(loByte), .hiByte(hiByte)
   );

   rhWordCount uWordCount
   (
      .clk(clk), .rst(rst), .devReset(devReset), .clrPulse(clrPulse),
      .wcWrite(wcWrite), .loByte(loByte), .hiByte(hiByte),
      .writeWord(writeWord), .dmaStep(dmaStep), .wc(wc), .wcLast(wcLast)
   );

   rhBusAddr uBusAddr
   (
      .clk(clk), .rst(rst), .devReset(devReset), .clrPulse(clrPulse),
      .baWrite(baWrite), .loByte(loByte), .hiByte(hiByte),
      .writeWord(writeWord), .dmaStep(dmaStep), .ba(ba)
   );

   // Sequencer owns CS1 and both external handshakes
   rhDmaCtrl uDmaCtrl
   (
      .clk(clk), .rst(rst), .devReset(devReset),
      .cs1Write(cs1Write), .writeWord(writeWord), .wcLast(wcLast), .ba(ba),
      .cs1Value(cs1Value), .clrPulse(clrPulse), .dmaStep(dmaStep), .irq(irq),
      .memReq(memReq), .memWrite(memWrite), .memAddr(memAddr),
      .memDataO(memDataO), .memAck(memAck), .memDataI(memDataI),
      .driveInData(driveInData), .driveInValid(driveInValid),
      .driveInReady(driveInReady), .driveOutData(driveOutData),
      .driveOutValid(driveOutValid), .driveOutReady(driveOutReady)
   );

endmodule

// File: project.f
+incdir+common
common/rhRegPkg.sv
common/rhDmaPkg.sv
rhRegs/rhRegDecode.sv
rhRegs/rhWordCount.sv
rhRegs/rhBusAddr.sv
design/rhDmaCtrl.sv
design/rhTop.sv
tb/rhMemModel.sv
tb/rhTb.sv

// File: rhRegs/rhBusAddr.sv
// RH11 bus address register, word aligned, bit 0 always reads zero
// Steps by two and wraps inside 16 bits, no carry into the extension bits
`timescale 1ns/1ns

`include "rh_consts.svh"

module rhBusAddr
(
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      devReset,
   input  logic                      clrPulse,
   input  logic                      baWrite,
   input  logic                      loByte,
   input  logic                      hiByte,
   input  rhRegPkg::devWord_u        writeWord,
   input  logic                      dmaStep,
   output logic [`RH_WORD_WIDTH-1:0] ba
);

   // Only the word address is stored
   logic [`RH_WORD_WIDTH-1:1] baWord;
   logic [7:0]                loData;

   assign loData = `RH_LO(writeWord.raw);
   assign ba     = {baWord, 1'b0};

   // Same priority as WC
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         baWord <= '0;
      else if (devReset || clrPulse)
         baWord <= '0;
      else if (baWrite)
      begin
         if (hiByte)
            baWord[15:8] <= `RH_HI(writeWord.raw);
         // Written bit 0 is dropped
         if (loByte)
            baWord[7:1] <= loData[7:1];
      end
      else if (dmaStep)
         // One word is two bytes
         baWord <= baWord + 1'b1;
   end

endmodule

// File: rhRegs/rhRegDecode.sv
// Device bus slave for CS1, WC and BA with a four-phase handshake
// Host must hold address, data and lanes stable while devReq is high
// devDataO is only valid while devAck is high
`timescale 1ns/1ns

`include "rh_consts.svh"

module rhRegDecode
(
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       devReq,
   input  logic                       devWrite,
   input  logic [2:0]                 devAddr,
   input  logic                       devLoByte,
   input  logic                       devHiByte,
   input  logic [0:`RH_DEV_WIDTH-1]   devDataI,
   input  logic [`RH_WORD_WIDTH-1:0]  wcValue,
   input  logic [`RH_WORD_WIDTH-1:0]  baValue,
   input  logic [`RH_WORD_WIDTH-1:0]  cs1Value,
   output logic                       devAck,
   output logic [0:`RH_DEV_WIDTH-1]   devDataO,
   output logic                       wcWrite,
   output logic                       baWrite,
   output logic                       cs1Write,
   output rhRegPkg::devWord_u         writeWord,
   output logic                       loByte,
   output logic                       hiByte
);

   // Big-endian device bus to little-endian word
   logic [`RH_DEV_WIDTH-1:0] devLe;
   rhRegPkg::regSel_t        sel;
   logic [`RH_WORD_WIDTH-1:0] rdValue;
   // First cycle of a handshake
   logic                     ackRise;

   assign devLe   = devDataI;
   assign ackRise = devReq & ~devAck;

   // Register lanes straight from the host
   assign loByte = devLoByte;
   assign hiByte = devHiByte;

   always_comb
   begin
      writeWord.raw = {`RH_HI(devLe), `RH_LO(devLe)};
   end

   // Address decode
   always_comb
   begin
      case (devAddr)
         `RH_OFF_CS1: sel = rhRegPkg::selCs1;
         `RH_OFF_WC:  sel = rhRegPkg::selWc;
         `RH_OFF_BA:  sel = rhRegPkg::selBa;
         default:     sel = rhRegPkg::selNone;
      endcase
   end

   // Read mux, unmapped offsets read zero
   always_comb
   begin
      case (sel)
         rhRegPkg::selCs1: rdValue = cs1Value;
         rhRegPkg::selWc:  rdValue = wcValue;
         rhRegPkg::selBa:  rdValue = baValue;
         default:          rdValue = '0;
      endcase
   end

   //////////////////////////////////////////////////////////////////////
   // Handshake and write strobes
   //////////////////////////////////////////////////////////////////////

   // devAck follows devReq by one clock in both directions
   // Strobes fire once, in the cycle devAck rises
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         devAck   <= 1'b0;
         wcWrite  <= 1'b0;
         baWrite  <= 1'b0;
         cs1Write <= 1'b0;
      end
      else
      begin
         devAck   <= devReq;
         wcWrite  <= ackRise & devWrite & (sel == rhRegPkg::selWc);
         baWrite  <= ackRise & devWrite & (sel == rhRegPkg::selBa);
         cs1Write <= ackRise & devWrite & (sel == rhRegPkg::selCs1);
      end
   end

   // Read data captured at the start of the handshake
   always_ff @(posedge clk)
   begin
      if (ackRise && !devWrite)
         devDataO <= {{(`RH_DEV_WIDTH-`RH_WORD_WIDTH){1'b0}}, rdValue};
   end

   // One strobe at most, and only on the rising edge of devAck
   assert property (@(posedge clk) disable iff (rst)
      (wcWrite | baWrite | cs1Write) |-> $onehot({wcWrite, baWrite, cs1Write}) && $rose(devAck));

endmodule

// File: rhRegs/rhWordCount.sv
// RH11 word count register, loaded by the host as a negative count
// Counts up once per DMA step, wcLast flags the final word
`timescale 1ns/1ns

`include "rh_consts.svh"

module rhWordCount
(
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      devReset,
   input  logic                      clrPulse,
   input  logic                      wcWrite,
   input  logic                      loByte,
   input  logic                      hiByte,
   input  rhRegPkg::devWord_u        writeWord,
   input  logic                      dmaStep,
   output logic [`RH_WORD_WIDTH-1:0] wc,
   output logic                      wcLast
);

   // All ones, so the coming step brings WC to zero
   assign wcLast = &wc;

   // Clear first, then host write, then step
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         wc <= '0;
      else if (devReset || clrPulse)
         wc <= '0;
      else if (wcWrite)
      begin
         // Each lane written on its own
         if (hiByte)
            wc[15:8] <= `RH_HI(writeWord.raw);
         if (loByte)
            wc[7:0] <= `RH_LO(writeWord.raw);
      end
      else if (dmaStep)
         wc <= wc + 1'b1;
   end

   // Host must not touch WC while the sequencer steps it
   assert property (@(posedge clk) disable iff (rst)
      dmaStep |-> !wcWrite);

endmodule

// File: tb/rhMemModel.sv
// Behavioral memory for the RH11 testbench, 16-bit words on an 18-bit byte address
// Acknowledge comes after a random delay of 0 to 4 clocks
// Words never written read back a fill value built from the whole address
`timescale 1ns/1ns

`include "rh_consts.svh"

module rhMemModel
(
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      memReq,
   input  logic                      memWrite,
   input  logic [`RH_ADDR_WIDTH-1:0] memAddr,
   input  logic [`RH_WORD_WIDTH-1:0] memDataO,
   output logic                      memAck,
   output logic [`RH_WORD_WIDTH-1:0] memDataI
);

   // Sparse storage keyed by word address
   logic [`RH_WORD_WIDTH-1:0] mem [int unsigned];
   int                        delay;

   function automatic logic [15:0] fillWord(input logic [17:0] addr);
      return addr[15:0] ^ {addr[7:0], addr[15:8]} ^ {12'h5a3, addr[17:16], 2'b01};
   endfunction

   always @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         memAck   <= 1'b0;
         memDataI <= '0;
         delay    <= 0;
      end
      else if (memReq && !memAck)
      begin
         if (delay == 0)
         begin
            memAck <= 1'b1;
            if (memWrite)
               mem[memAddr[17:1]] = memDataO;
            else if (mem.exists(memAddr[17:1]))
               memDataI <= mem[memAddr[17:1]];
            else
               memDataI <= fillWord(memAddr);
         end
         else
            delay <= delay - 1;
      end
      else if (memAck && !memReq)
      begin
         // Release, then pick the next latency
         memAck <= 1'b0;
         delay  <= $urandom_range(0, 4);
      end
   end

endmodule

// File: tb/rhTb.sv
// Testbench for the RH11 data channel covering register access, clears, DMA and irq
// Memory latency and drive gaps are random from a fixed seed
// Drive side runs inside this module and memory is rhMemModel
`timescale 1ns/1ns

`include "rh_consts.svh"

module rhTb;

   localparam int totalWords = 19;
   localparam int limitNs = (totalWords * 40 + 2000) * 10;

   logic clk = 1'b0;
   logic rst;
   logic devReset, devReq, devWrite, devLoByte, devHiByte;
   logic [2:0] devAddr;
   logic [0:`RH_DEV_WIDTH-1] devDataI, devDataO;
   logic devAck, memReq, memWrite, memAck, irq;
   logic [`RH_ADDR_WIDTH-1:0] memAddr;
   logic [15:0] memDataO, memDataI;
   logic [15:0] driveInData, driveOutData;
   logic driveInValid, driveInReady, driveOutValid, driveOutReady;

   // Reference state and checker inputs
   logic [15:0] refWc, refBa, expRead;
   logic readChk, ieRef, xferRead;
   string readName;
   int errors = 0, testNum = 0, testsOk = 0, errBefore;
   int inIdx, inGap, outIdx, memWrCount;
   int xferFirst, outFirst;
   logic [15:0] xferBase, outBase;
   logic [17:0] expMemAddr, expOutAddr;
   logic [15:0] expMemData, expOut;

   always #5 clk = ~clk;

   rhTop dut
   (
      .clk(clk), .rst(rst), .devReset(devReset),
      .devReq(devReq), .devWrite(devWrite), .devAddr(devAddr),
      .devLoByte(devLoByte), .devHiByte(devHiByte), .devDataI(devDataI),
      .devAck(devAck), .devDataO(devDataO),
      .memReq(memReq), .memWrite(memWrite), .memAddr(memAddr),
      .memDataO(memDataO), .memAck(memAck), .memDataI(memDataI),
      .driveInData(driveInData), .driveInValid(driveInValid),
      .driveInReady(driveInReady), .driveOutData(driveOutData),
      .driveOutValid(driveOutValid), .driveOutReady(driveOutReady), .irq(irq)
   );

   rhMemModel uMem
   (
      .clk(clk), .rst(rst), .memReq(memReq), .memWrite(memWrite),
      .memAddr(memAddr), .memDataO(memDataO), .memAck(memAck), .memDataI(memDataI)
   );

   function automatic logic [15:0] fillPattern(input logic [17:0] addr);
      return addr[15:0] ^ {addr[7:0], addr[15:8]} ^ {12'h5a3, addr[17:16], 2'b01};
   endfunction

   function automatic logic [15:0] driveWord(input int idx);
      return 16'(idx * 977 + 2021);
   endfunction

   function automatic logic [15:0] mergeLanes(input logic [15:0] old, input logic [15:0] data,
                                              input logic lo, input logic hi);
      return {hi ? data[15:8] : old[15:8], lo ? data[7:0] : old[7:0]};
   endfunction

   // Expected memory and drive traffic
   // Extension bits stay zero
   assign expMemAddr = {2'b00, xferBase + 16'(2 * (memWrCount - xferFirst))};
   assign expMemData = driveWord(memWrCount);
   assign expOutAddr = {2'b00, outBase + 16'(2 * (outIdx - outFirst))};
   assign expOut     = fillPattern(expOutAddr);

   //////////////////////////////////////////////////////////////////////
   // Drive model
   //////////////////////////////////////////////////////////////////////

   always @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         driveInValid  <= 1'b0;
         driveInData   <= '0;
         driveOutReady <= 1'b0;
         inIdx         <= 0;
         inGap         <= 0;
         outIdx        <= 0;
         memWrCount    <= 0;
      end
      else
      begin
         if (driveInValid && driveInReady)
         begin
            inIdx        <= inIdx + 1;
            driveInValid <= 1'b0;
            inGap        <= $urandom_range(0, 3);
         end
         else if (!driveInValid)
         begin
            if (inGap == 0)
            begin
               driveInValid <= 1'b1;
               driveInData  <= driveWord(inIdx);
            end
            else
               inGap <= inGap - 1;
         end
         driveOutReady <= ($urandom_range(0, 3) != 0);
         if (driveOutValid && driveOutReady)
            outIdx <= outIdx + 1;
         if (memReq && memAck && memWrite)
            memWrCount <= memWrCount + 1;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Assertions
   //////////////////////////////////////////////////////////////////////

   // Four-phase device handshake
   assert property (@(posedge clk) disable iff (rst) devReq |=> devAck)
      else
      begin
         $display("device handshake: devAck did not follow devReq high");
         errors++;
      end
   assert property (@(posedge clk) disable iff (rst) !devReq |=> !devAck)
      else
      begin
         $display("device handshake: devAck did not fall after devReq");
         errors++;
      end

   assert property (@(posedge clk) disable iff (rst) readChk |-> devDataO == {20'h0, expRead})
      else
      begin
         $display("FAILED %0t devDataO (%s) got %h expected %h",
                  $time, readName, $sampled(devDataO[20:35]), $sampled(expRead));
         errors++;
      end

   assert property (@(posedge clk) disable iff (rst)
      memReq && memAck && memWrite |-> memAddr == expMemAddr)
      else
      begin
         $display("FAILED %0t memAddr got %h expected %h",
                  $time, $sampled(memAddr), $sampled(expMemAddr));
         errors++;
      end
   assert property (@(posedge clk) disable iff (rst)
      memReq && memAck && memWrite |-> memDataO == expMemData)
      else
      begin
         $display("FAILED %0t memDataO got %h expected %h",
                  $time, $sampled(memDataO), $sampled(expMemData));
         errors++;
      end

   // Memory direction follows the started function
   assert property (@(posedge clk) disable iff (rst) memReq |-> memWrite == xferRead)
      else
      begin
         $display("FAILED %0t memWrite got %b expected %b",
                  $time, $sampled(memWrite), $sampled(xferRead));
         errors++;
      end

   // Drive output stream in memory order
   assert property (@(posedge clk) disable iff (rst)
      driveOutValid && driveOutReady |-> driveOutData == expOut)
      else
      begin
         $display("FAILED %0t driveOutData got %h expected %h",
                  $time, $sampled(driveOutData), $sampled(expOut));
         errors++;
      end

   assert property (@(posedge clk) disable iff (rst) $rose(irq) |-> ieRef)
      else
      begin
         $display("irq rose while IE was clear");
         errors++;
      end
   assert property (@(posedge clk) disable iff (rst) dut.cs1Write |=> !irq)
      else
      begin
         $display("irq stayed high after a CS1 write");
         errors++;
      end

   //////////////////////////////////////////////////////////////////////
   // Bus tasks
   //////////////////////////////////////////////////////////////////////

   task automatic busWrite(input logic [2:0] addr, input logic [15:0] data,
                           input logic lo, input logic hi);
      @(posedge clk);
      devReq    <= 1'b1;
      devWrite  <= 1'b1;
      devAddr   <= addr;
      devLoByte <= lo;
      devHiByte <= hi;
      devDataI  <= {20'h0, data};
      @(posedge clk);
      while (!devAck)
         @(posedge clk);
      devReq <= 1'b0;
      @(posedge clk);
      while (devAck)
         @(posedge clk);
   endtask

   task automatic busRead(input logic [2:0] addr, input logic check, input logic [15:0] exp,
                          input string name, output logic [15:0] data);
      @(posedge clk);
      devReq   <= 1'b1;
      devWrite <= 1'b0;
      devAddr  <= addr;
      @(posedge clk);
      while (!devAck)
         @(posedge clk);
      data     = devDataO[20:35];
      devReq   <= 1'b0;
      readChk  <= check;
      expRead  <= exp;
      readName = name;
      @(posedge clk);
      readChk <= 1'b0;
      while (devAck)
         @(posedge clk);
   endtask

   task automatic checkReg(input logic [2:0] addr, input logic [15:0] exp, input string name);
      logic [15:0] d;
      busRead(addr, 1'b1, exp, name, d);
   endtask

   task automatic checkEq(input string name, input logic [15:0] got, input logic [15:0] exp);
      assert (got === exp)
      else
      begin
         $display("FAILED %0t %s got %h expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   // Poll CS1 until RDY is back
   task automatic waitReady();
      logic [15:0] d;
      d = '0;
      while (!d[`RH_CS1_RDY])
         busRead(`RH_OFF_CS1, 1'b0, '0, "CS1", d);
   endtask

   task automatic writeWc(input logic [15:0] data, input logic lo, input logic hi);
      busWrite(`RH_OFF_WC, data, lo, hi);
      refWc = mergeLanes(refWc, data, lo, hi);
   endtask

   task automatic writeBa(input logic [15:0] data, input logic lo, input logic hi);
      busWrite(`RH_OFF_BA, data, lo, hi);
      refBa = mergeLanes(refBa, data, lo, hi) & 16'hfffe;
   endtask

   task automatic beginTest();
      testNum++;
      errBefore = errors;
   endtask

   task automatic endTest(input string name);
      if (errors == errBefore)
         testsOk++;
      $display("test %0d %s: %s", testNum, name, (errors == errBefore) ? "ok" : "errors");
   endtask

   // Set up WC and BA, then start a transfer with a CS1 write
   task automatic startXfer(input int n, input logic [15:0] base, input logic [15:0] cs1);
      writeWc(16'(-n), 1'b1, 1'b1);
      writeBa(base, 1'b1, 1'b1);
      xferBase  = base;
      xferFirst = memWrCount;
      outBase   = base;
      outFirst  = outIdx;
      xferRead  = cs1[`RH_CS1_FUNC] == rhDmaPkg::fnReadData;
      busWrite(`RH_OFF_CS1, cs1, 1'b1, 1'b1);
   endtask

   //////////////////////////////////////////////////////////////////////
   // Watchdog and main sequence
   //////////////////////////////////////////////////////////////////////

   initial
   begin
      #(limitNs);
      $display("watchdog: run did not finish in %0d ns", limitNs);
      $display("SOME TESTS FAILED");
      $finish;
   end

   initial
   begin
      void'($urandom(32'h5bf4_bb30));
      rst = 1'b1;
      devReset = 1'b0;
      devReq = 1'b0;
      devWrite = 1'b0;
      devAddr = '0;
      devLoByte = 1'b0;
      devHiByte = 1'b0;
      devDataI = '0;
      readChk = 1'b0;
      expRead = '0;
      ieRef = 1'b0;
      xferRead = 1'b0;
      refWc = '0;
      refBa = '0;
      xferBase = '0;
      outBase = '0;
      xferFirst = 0;
      outFirst = 0;
      repeat (8) @(posedge clk);
      rst <= 1'b0;

      beginTest();
      // Handshake and DMA outputs idle out of reset
      checkEq("outputs after reset",
              {11'h0, devAck, memReq, driveInReady, driveOutValid, irq}, 16'h0000);
      checkReg(`RH_OFF_CS1, 16'h0080, "CS1 after reset");
      writeWc(16'h1234, 1'b1, 1'b1);
      checkReg(`RH_OFF_WC, refWc, "WC both lanes");
      writeWc(16'hffcd, 1'b1, 1'b0);
      checkReg(`RH_OFF_WC, refWc, "WC low lane");
      writeWc(16'hab00, 1'b0, 1'b1);
      checkReg(`RH_OFF_WC, refWc, "WC high lane");
      writeBa(16'h4567, 1'b1, 1'b1);
      checkReg(`RH_OFF_BA, 16'h4566, "BA both lanes");
      writeBa(16'h0033, 1'b1, 1'b0);
      checkReg(`RH_OFF_BA, refBa, "BA low lane");
      writeBa(16'h8800, 1'b0, 1'b1);
      checkReg(`RH_OFF_BA, refBa, "BA high lane");
      endTest("byte lanes");

      beginTest();
      writeWc(16'h5555, 1'b1, 1'b1);
      writeBa(16'h2222, 1'b1, 1'b1);
      // Drive clear is func 2
      busWrite(`RH_OFF_CS1, 16'h0004, 1'b1, 1'b1);
      checkReg(`RH_OFF_WC, 16'h0000, "WC after drive clear");
      checkReg(`RH_OFF_BA, 16'h0000, "BA after drive clear");
      checkReg(`RH_OFF_CS1, 16'h0084, "CS1 after drive clear");
      writeWc(16'h7777, 1'b1, 1'b1);
      writeBa(16'h3334, 1'b1, 1'b1);
      @(posedge clk);
      devReset <= 1'b1;
      @(posedge clk);
      devReset <= 1'b0;
      checkReg(`RH_OFF_WC, 16'h0000, "WC after devReset");
      checkReg(`RH_OFF_BA, 16'h0000, "BA after devReset");
      checkReg(`RH_OFF_CS1, 16'h0084, "CS1 after devReset");
      endTest("clearing");

      beginTest();
      startXfer(6, 16'h0100, 16'h0039);
      waitReady();
      checkEq("words written", 16'(memWrCount - xferFirst), 16'd6);
      checkReg(`RH_OFF_WC, 16'h0000, "WC after read data");
      checkReg(`RH_OFF_BA, 16'h010c, "BA after read data");
      checkReg(`RH_OFF_CS1, 16'h00b8, "CS1 after read data");
      endTest("read data");

      beginTest();
      startXfer(8, 16'h0400, 16'h0031);
      waitReady();
      checkEq("words to drive", 16'(outIdx - outFirst), 16'd8);
      checkReg(`RH_OFF_WC, 16'h0000, "WC after write data");
      checkReg(`RH_OFF_BA, 16'h0410, "BA after write data");
      checkReg(`RH_OFF_CS1, 16'h00b0, "CS1 after write data");
      endTest("write data");

      beginTest();
      ieRef = 1'b1;
      startXfer(3, 16'h0800, 16'h0079);
      // GO while busy is ignored
      busWrite(`RH_OFF_CS1, 16'h0071, 1'b1, 1'b1);
      while (!irq)
         @(posedge clk);
      checkEq("words with GO while busy", 16'(memWrCount - xferFirst), 16'd3);
      checkReg(`RH_OFF_CS1, 16'h00f8, "CS1 with IE");
      ieRef = 1'b0;
      busWrite(`RH_OFF_CS1, 16'h0038, 1'b1, 1'b1);
      checkEq("irq after CS1 write", {15'h0, irq}, 16'h0000);
      startXfer(2, 16'h0c00, 16'h0039);
      waitReady();
      repeat (3) @(posedge clk);
      checkEq("irq without IE", {15'h0, irq}, 16'h0000);
      checkReg(`RH_OFF_WC, 16'h0000, "WC after second transfer");
      endTest("interrupt");

      repeat (4) @(posedge clk);
      $display("tests %0d, passed %0d, errors %0d", testNum, testsOk, errors);
      if (errors == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule
